// File: Bender.yml
package:
  name: na_conf

sources:
  - verilog/na_pkg.sv
  - verilog/na_seed_gen.sv
  - verilog/na_conf_regs.sv
  - verilog/na_bus_ctrl.sv
  - verilog/na_conf_top.sv
  - target: test
    files:
      - testbench/na_conf_assertions.sv
      - testbench/na_conf_checker.sv
      - testbench/tb_na_conf.sv

// File: src.f
verilog/na_pkg.sv
verilog/na_seed_gen.sv
verilog/na_conf_regs.sv
verilog/na_bus_ctrl.sv
verilog/na_conf_top.sv
testbench/na_conf_assertions.sv
testbench/na_conf_checker.sv
testbench/tb_na_conf.sv

// File: testbench/na_conf_assertions.sv
// bus protocol assertions for the configuration bus controller
`timescale 1ns/100ps
`default_nettype none

module na_conf_assertions (
   input wire                    clk,
   input wire                    rst,
   input wire                    cyc,
   input wire                    stb,
   input wire                    ack,
   input wire                    err,
   input na_pkg::na_bus_state_e  state          // controller fsm state
);

   wire req  = (state == na_pkg::bus_idle) && cyc && stb;   // request sampled at this edge
   wire resp = ack || err;

   int failures = 0;                              // failed assertion count

   a_exclusive: assert property (@(posedge clk) disable iff (rst) !(ack && err))
      else begin
         failures++;
         $error("ack and err are high together");
      end

   a_one_cycle: assert property (@(posedge clk) disable iff (rst) resp |=> !resp)
      else begin
         failures++;
         $error("response lasts longer than one cycle");
      end

   // quiet for one edge, then the answer
   a_latency: assert property (@(posedge clk) disable iff (rst) req |=> !resp ##1 resp)
      else begin
         failures++;
         $error("response did not come two edges after the request");
      end

   a_requested: assert property (@(posedge clk) disable iff (rst) resp |-> $past(req, 2))
      else begin
         failures++;
         $error("response without a sampled request");
      end

endmodule

`default_nettype wire

// File: testbench/na_conf_checker.sv
// reference model of the register map and seed sequence that checks every bus response
`timescale 1ns/100ps
`default_nettype none

module na_conf_checker #(
   parameter logic [31:0]        TILE_ID         = 32'd0,
   parameter logic [31:0]        CORE_BASE       = 32'd0,
   parameter logic [31:0]        NUM_TILES       = 32'd1,
   parameter logic [31:0]        CORES_PER_TILE  = 32'd1,
   parameter logic [31:0]        GMEM_SIZE       = 32'd0,
   parameter logic [31:0]        GMEM_TILE       = 32'd0,
   parameter logic [31:0]        LMEM_SIZE       = 32'd0,
   parameter logic [31:0]        DMA_SLOTS       = 32'd0,
   parameter logic               ENABLE_MPSIMPLE = 1'b0,
   parameter logic               ENABLE_DMA      = 1'b0,
   parameter int                 NUM_CTS         = 1,
   parameter na_pkg::na_ctlist_t CTLIST          = '0,
   parameter logic [2:0]         CDC_DEFAULT     = 3'd0,
   parameter logic [31:0]        SEED_INIT       = 32'h0000_0001
) (
   input  wire         clk,
   input  wire         rst,
   input  wire         cyc,
   input  wire         stb,
   input  wire [15:0]  adr,
   input  wire         we,
   input  wire [31:0]  wr_data,
   input  wire [31:0]  rd_data,
   input  wire         ack,
   input  wire         err,
   input  wire [2:0]   cdc_conf,
   input  wire         cdc_enable,
   output int          error_count
);

   logic [31:0] seed_model;                    // next seed software should see
   logic [2:0]  cdc_model;
   logic        busy;                          // request sampled, answer pending
   int          edges;                         // edges since the request was sampled
   logic        exp_err;
   logic [31:0] exp_data;
   logic        exp_seed;                      // seed read, lfsr steps
   logic        exp_cdc_wr;
   logic [2:0]  exp_cdc;
   logic        req_we;
   string       name;
   int          errors = 0;

   assign error_count = errors;

   // galois step, right shift with feedback mask
   function automatic logic [31:0] seed_after(input logic [31:0] s);
      return s[0] ? ({1'b0, s[31:1]} ^ na_pkg::na_seed_taps) : {1'b0, s[31:1]};
   endfunction

   task automatic compare(input string what, input logic [31:0] expv, input logic [31:0] actv);
      if (expv !== actv) begin
         errors++;
         $display("CHECK FAILED %s: expected %h actual %h", what, expv, actv);
      end
   endtask

   // expected answer from the register map
   task automatic predict(input logic [15:0] a, input logic w, input logic [31:0] d);
      logic [5:0] e;
      e          = a[6:1];                     // halfword entry in the list window
      exp_err    = 1'b0;
      exp_data   = 32'h0;
      if ((a[11:0] >= 12'h200) && (a[11:0] <= 12'h27e) && !a[0]) begin
         if (int'(e) < NUM_CTS) begin
            exp_data = e[0] ? {16'h0, CTLIST[NUM_CTS-1-int'(e)]}
                            : {CTLIST[NUM_CTS-1-int'(e)], 16'h0};
         end else begin
            exp_err = 1'b1;                    // past the list end
         end
      end else begin
         case (a[11:0])
            12'h000: exp_data = TILE_ID;
            12'h004: exp_data = NUM_TILES;
            12'h00c: exp_data = {30'h0, ENABLE_DMA, ENABLE_MPSIMPLE};
            12'h010: exp_data = CORE_BASE;
            12'h018: exp_data = CORES_PER_TILE;
            12'h01c: exp_data = GMEM_SIZE;
            12'h020: exp_data = GMEM_TILE;
            12'h024: exp_data = LMEM_SIZE;
            12'h028: exp_data = 32'(NUM_CTS);
            12'h02c: exp_data = seed_model;    // value before the step
            12'h030: exp_data = DMA_SLOTS;
            12'h100: exp_data = 32'd1;
            12'h104: exp_data = 32'd1;
            12'h108: exp_data = {29'h0, cdc_model};
            default: exp_err  = 1'b1;          // hole in the map
         endcase
      end
      if ((a[15:12] != 4'h0) || (w && (a != 16'h0108))) begin
         exp_err = 1'b1;                       // outside window or read-only target
      end
      exp_seed   = (a == 16'h002c) && !w;
      exp_cdc_wr = (a == 16'h0108) && w;
      exp_cdc    = d[2:0];
   endtask

   always @(posedge clk) begin
      if (rst) begin
         seed_model = SEED_INIT;
         cdc_model  = CDC_DEFAULT;
         busy       = 1'b0;
      end else if (busy) begin
         edges++;
         if (edges == 2) begin
            compare({name, " err"}, 32'(exp_err), 32'(err));
            compare({name, " ack"}, 32'(!exp_err), 32'(ack));
            if (!exp_err && !req_we) begin
               compare({name, " read data"}, exp_data, rd_data);
            end
            compare({name, " cdc_enable"}, 32'(exp_cdc_wr), 32'(cdc_enable));
            if (exp_seed) begin
               seed_model = seed_after(seed_model);
            end
            if (exp_cdc_wr) begin
               cdc_model = exp_cdc;            // register already holds it
            end
            busy = 1'b0;
         end else begin
            compare({name, " early response"}, 32'h0, 32'(ack || err));
            compare({name, " early cdc_enable"}, 32'h0, 32'(cdc_enable));
         end
      end else begin
         compare("idle response", 32'h0, 32'(ack || err));
         compare("idle cdc_enable", 32'h0, 32'(cdc_enable));
         if (cyc && stb) begin
            predict(adr, we, wr_data);
            req_we = we;
            name   = $sformatf("%s %04h", we ? "write" : "read", adr);
            edges  = 0;
            busy   = 1'b1;
         end
      end
      if (!rst) begin
         compare("cdc_conf", 32'(cdc_model), 32'(cdc_conf));
      end
   end

endmodule

`default_nettype wire

// File: testbench/tb_na_conf.sv
// testbench for the configuration block, random bus master stepped from an lfsr
`timescale 1ns/100ps
`default_nettype none

module tb_na_conf;

   localparam int N_REQ       = 400;
   localparam int CYCLE_LIMIT = N_REQ * 10 + 50;   // a request takes at most 7 cycles

   localparam logic [31:0] TILE_ID         = 32'h0000_0007;
   localparam logic [31:0] CORE_BASE       = 32'h0000_001c;
   localparam logic [31:0] NUM_TILES       = 32'h0000_0010;
   localparam logic [31:0] CORES_PER_TILE  = 32'h0000_0004;
   localparam logic [31:0] GMEM_SIZE       = 32'h0100_0000;
   localparam logic [31:0] GMEM_TILE       = 32'h0000_000f;
   localparam logic [31:0] LMEM_SIZE       = 32'h0004_0000;
   localparam logic [31:0] DMA_SLOTS       = 32'h0000_0006;
   localparam logic        ENABLE_MPSIMPLE = 1'b1;
   localparam logic        ENABLE_DMA      = 1'b0;
   localparam int          NUM_CTS         = 5;
   localparam logic [2:0]  CDC_DEFAULT     = 3'd5;
   localparam logic [31:0] SEED_INIT       = 32'h1357_9bdf;
   // element 0 is the rightmost id
   localparam na_pkg::na_ctlist_t CTS = {944'h0, 16'h0033, 16'h0021, 16'h0017, 16'h000b,
                                         16'h0005};

   logic        clk;
   logic        rst;
   logic        cyc;
   logic        stb;
   logic        we;
   logic [15:0] adr;
   logic [31:0] wr_data;
   logic [31:0] rd_data;
   logic        ack;
   logic        err;
   logic [2:0]  cdc_conf;
   logic        cdc_enable;
   logic [31:0] rng;                               // stimulus lfsr state
   int          checker_errors;
   int          assert_errors;                     // from the bound protocol checks
   int          cycles = 0;

   always #4 clk = ~clk;

   na_conf_top #(
      .TILE_ID (TILE_ID), .CORE_BASE (CORE_BASE), .NUM_TILES (NUM_TILES),
      .CORES_PER_TILE (CORES_PER_TILE), .GMEM_SIZE (GMEM_SIZE), .GMEM_TILE (GMEM_TILE),
      .LMEM_SIZE (LMEM_SIZE), .DMA_SLOTS (DMA_SLOTS), .ENABLE_MPSIMPLE (ENABLE_MPSIMPLE),
      .ENABLE_DMA (ENABLE_DMA), .NUM_CTS (NUM_CTS), .CTLIST (CTS),
      .CDC_DEFAULT (CDC_DEFAULT), .SEED_INIT (SEED_INIT)
   ) dut (
      .clk (clk), .rst (rst), .cyc (cyc), .stb (stb), .adr (adr), .we (we),
      .wr_data (wr_data), .rd_data (rd_data), .ack (ack), .err (err),
      .cdc_conf (cdc_conf), .cdc_enable (cdc_enable)
   );

   na_conf_checker #(
      .TILE_ID (TILE_ID), .CORE_BASE (CORE_BASE), .NUM_TILES (NUM_TILES),
      .CORES_PER_TILE (CORES_PER_TILE), .GMEM_SIZE (GMEM_SIZE), .GMEM_TILE (GMEM_TILE),
      .LMEM_SIZE (LMEM_SIZE), .DMA_SLOTS (DMA_SLOTS), .ENABLE_MPSIMPLE (ENABLE_MPSIMPLE),
      .ENABLE_DMA (ENABLE_DMA), .NUM_CTS (NUM_CTS), .CTLIST (CTS),
      .CDC_DEFAULT (CDC_DEFAULT), .SEED_INIT (SEED_INIT)
   ) u_checker (
      .clk (clk), .rst (rst), .cyc (cyc), .stb (stb), .adr (adr), .we (we),
      .wr_data (wr_data), .rd_data (rd_data), .ack (ack), .err (err),
      .cdc_conf (cdc_conf), .cdc_enable (cdc_enable), .error_count (checker_errors)
   );

   bind na_bus_ctrl na_conf_assertions u_bus_assert (
      .clk (clk), .rst (rst), .cyc (cyc), .stb (stb), .ack (ack), .err (err), .state (state)
   );

   assign assert_errors = dut.u_bus_ctrl.u_bus_assert.failures;

   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return s[0] ? ({1'b0, s[31:1]} ^ 32'hb4bc_d35c) : {1'b0, s[31:1]};
   endfunction

   // one lfsr step per bit
   task automatic take_bits(input int n, output logic [31:0] v);
      v = '0;
      for (int i = 0; i < n; i++) begin
         v   = {v[30:0], rng[0]};
         rng = lfsr_step(rng);
      end
   endtask

   function automatic logic [15:0] mapped_offset(input logic [3:0] i);
      case (i)
         4'd0:    return 16'h0000;
         4'd1:    return 16'h0004;
         4'd2:    return 16'h000c;
         4'd3:    return 16'h0010;
         4'd4:    return 16'h0018;
         4'd5:    return 16'h001c;
         4'd6:    return 16'h0020;
         4'd7:    return 16'h0024;
         4'd8:    return 16'h0028;
         4'd9:    return 16'h0030;
         4'd10:   return 16'h0100;
         4'd11:   return 16'h0104;
         4'd12:   return 16'h0108;
         default: return 16'h002c;                 // seed gets extra weight
      endcase
   endfunction

   // called on a falling edge, returns on the falling edge inside the response
   task automatic bus_access(input logic [15:0] a, input logic w, input logic [31:0] d);
      adr     = a;
      we      = w;
      wr_data = d;
      cyc     = 1'b1;
      stb     = 1'b1;
      do @(negedge clk); while (!(ack || err));
      cyc = 1'b0;
      stb = 1'b0;
   endtask

   always @(posedge clk) begin
      cycles++;
      if (cycles >= CYCLE_LIMIT) begin
         $display("timeout: run still busy after %0d cycles", CYCLE_LIMIT);
         $display("errors: %0d", checker_errors + assert_errors + 1);
         $display("CHECKS FAILED");
         $finish;
      end
   end

   initial begin
      logic [31:0] gap;
      logic [31:0] data;
      logic [31:0] kind;
      logic [31:0] pick;
      logic [15:0] a;
      logic        w;
      clk     = 1'b0;
      rst     = 1'b1;
      cyc     = 1'b0;
      stb     = 1'b0;
      we      = 1'b0;
      adr     = 16'h0;
      wr_data = 32'h0;
      rng     = 32'd71263;
      repeat (2) @(negedge clk);
      rst = 1'b0;
      for (int i = 0; i < N_REQ; i++) begin
         take_bits(2, gap);
         repeat (gap + 1) @(negedge clk);          // 1 to 4 idle cycles
         take_bits(32, data);
         take_bits(4, kind);
         take_bits(4, pick);
         w = 1'b0;
         if (i == 0) begin
            a = 16'h0108;                          // setting straight after reset
         end else if (i == 1) begin
            a = 16'h002c;                          // first seed
         end else begin
            case (kind[3:0])
               4'd0, 4'd1, 4'd2, 4'd3, 4'd4, 4'd5, 4'd6: a = mapped_offset(pick[3:0]);
               4'd7:  a = 16'h0200 + {pick[2:0], 1'b0};   // list entries 0 to 7
               4'd8: begin
                  a = 16'h0200 + {pick[2:0], 1'b0};
                  w = pick[3];                     // list writes err
               end
               4'd9:  a = 16'h002c;
               4'd10: a = {4'h0, data[27:16]};     // any offset, holes likely
               4'd11: a = {pick[3:0] | 4'h1, data[27:16]};  // high bits set
               4'd12: begin
                  a = mapped_offset(pick[3:0]);
                  w = 1'b1;
               end
               4'd13, 4'd14: begin
                  a = 16'h0108;
                  w = 1'b1;
               end
               default: a = 16'h0108;
            endcase
         end
         bus_access(a, w, data);
      end
      repeat (3) @(negedge clk);                   // checker sees the last answer
      $display("errors: %0d checker, %0d assertions", checker_errors, assert_errors);
      if ((checker_errors == 0) && (assert_errors == 0)) begin
         $display("ALL CHECKS PASSED");
      end else begin
         $display("CHECKS FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: verilog/na_bus_ctrl.sv
// configuration bus controller that registers requests, decodes them and answers ack or err
`timescale 1ns/100ps
`default_nettype none

module na_bus_ctrl #(
   parameter int NUM_CTS = 1                        // compute tiles in the list
) (
   input  wire                           clk,
   input  wire                           rst,
   input  wire                           cyc,
   input  wire                           stb,
   input  wire [na_pkg::na_adr_w-1:0]    adr,
   input  wire                           we,
   input  wire [na_pkg::na_data_w-1:0]   wr_data,
   input  wire [na_pkg::na_data_w-1:0]   read_word,     // combinational from register file
   output logic [na_pkg::na_data_w-1:0]  rd_data,
   output logic                          ack,
   output logic                          err,
   output na_pkg::na_reg_e               sel,
   output logic [5:0]                    entry,
   output logic                          wr_en,
   output logic [2:0]                    wr_bits,
   output logic                          seed_step
);

   na_pkg::na_bus_state_e state;

   na_pkg::na_reg_e dec_sel;                         // decode of the live address
   logic [5:0]      dec_entry;
   logic            dec_err;
   logic            req_we;                          // latched write flag
   logic            req_err;                         // latched classification

   // address decode
   always_comb begin
      dec_entry = adr[6:1];                          // halfword index in list window
      dec_sel   = na_pkg::reg_none;
      if ((adr[11:7] == 5'b0_0100) && !adr[0]) begin
         dec_sel = na_pkg::reg_ctlist;               // 0x200 .. 0x27e
      end else begin
         case (adr[11:0])
            12'h000: dec_sel = na_pkg::reg_tile_id;
            12'h004: dec_sel = na_pkg::reg_num_tiles;
            12'h00c: dec_sel = na_pkg::reg_features;
            12'h010: dec_sel = na_pkg::reg_core_base;
            12'h018: dec_sel = na_pkg::reg_cores_per_tile;
            12'h01c: dec_sel = na_pkg::reg_gmem_size;
            12'h020: dec_sel = na_pkg::reg_gmem_tile;
            12'h024: dec_sel = na_pkg::reg_lmem_size;
            12'h028: dec_sel = na_pkg::reg_num_cts;
            12'h02c: dec_sel = na_pkg::reg_seed;
            12'h030: dec_sel = na_pkg::reg_dma_slots;
            12'h100: dec_sel = na_pkg::reg_cdc;
            12'h104: dec_sel = na_pkg::reg_cdc_dyn;
            12'h108: dec_sel = na_pkg::reg_cdc_conf;
            default: dec_sel = na_pkg::reg_none;     // holes and misaligned words
         endcase
      end
   end

   // error classes
   assign dec_err = (adr[15:12] != 4'h0)             // outside the 4k window
                  || (dec_sel == na_pkg::reg_none)
                  || ((dec_sel == na_pkg::reg_ctlist) && ({1'b0, dec_entry} >= 7'(NUM_CTS)))
                  || (we && (dec_sel != na_pkg::reg_cdc_conf)); // read-only target

   // request capture, only on a sampled request
   always_ff @(posedge clk) begin
      if ((state == na_pkg::bus_idle) && cyc && stb) begin
         sel     <= dec_sel;
         entry   <= dec_entry;
         wr_bits <= wr_data[2:0];                    // setting is 3 bits wide
         req_we  <= we;
         req_err <= dec_err;
      end
      if (state == na_pkg::bus_access) begin
         rd_data <= read_word;                       // pre-step seed lands here
      end
   end

   // handshake fsm, fixed two edge latency
   always_ff @(posedge clk) begin
      if (rst) begin
         state <= na_pkg::bus_idle;
         ack   <= 1'b0;
         err   <= 1'b0;
      end else begin
         ack <= 1'b0;                                // one cycle responses
         err <= 1'b0;
         case (state)
            na_pkg::bus_idle: begin
               if (cyc && stb) begin
                  state <= na_pkg::bus_access;
               end
            end
            na_pkg::bus_access: begin
               ack   <= !req_err;
               err   <= req_err;
               state <= na_pkg::bus_respond;
            end
            na_pkg::bus_respond: begin
               state <= na_pkg::bus_idle;            // master drops stb meanwhile
            end
            default: begin
               state <= na_pkg::bus_idle;
            end
         endcase
      end
   end

   // side effects fire at the edge that ends access
   assign wr_en     = (state == na_pkg::bus_access) && req_we && !req_err;
   assign seed_step = (state == na_pkg::bus_access) && !req_we && !req_err
                    && (sel == na_pkg::reg_seed);

endmodule

`default_nettype wire

// File: verilog/na_conf_regs.sv
// configuration register file with fixed tile values, compute tile list and clock-domain setting
`timescale 1ns/100ps
`default_nettype none

module na_conf_regs #(
   parameter logic [31:0]        TILE_ID         = 32'd0,
   parameter logic [31:0]        CORE_BASE       = 32'd0,
   parameter logic [31:0]        NUM_TILES       = 32'd1,
   parameter logic [31:0]        CORES_PER_TILE  = 32'd1,
   parameter logic [31:0]        GMEM_SIZE       = 32'd0,
   parameter logic [31:0]        GMEM_TILE       = 32'd0,
   parameter logic [31:0]        LMEM_SIZE       = 32'd0,
   parameter logic [31:0]        DMA_SLOTS       = 32'd0,
   parameter logic               ENABLE_MPSIMPLE = 1'b0,
   parameter logic               ENABLE_DMA      = 1'b0,
   parameter int                 NUM_CTS         = 1,     // 1 .. 64
   parameter na_pkg::na_ctlist_t CTLIST          = '0,
   parameter logic [2:0]         CDC_DEFAULT     = 3'd0
) (
   input  wire                           clk,
   input  wire                           rst,
   input  na_pkg::na_reg_e               sel,
   input  wire [5:0]                     entry,       // list entry, valid below NUM_CTS
   input  wire                           wr_en,
   input  wire [2:0]                     wr_bits,
   input  wire [na_pkg::na_data_w-1:0]   seed,
   output logic [na_pkg::na_data_w-1:0]  read_word,
   output logic [2:0]                    cdc_conf,
   output logic                          cdc_enable
);

   wire  [15:0]                   ctlist_rev [na_pkg::na_max_cts];  // indexed by entry
   logic [15:0]                   list_id;
   logic [na_pkg::na_data_w-1:0]  feat_word;

   // list is served back to front, entry e is element NUM_CTS-1-e
   for (genvar i = 0; i < na_pkg::na_max_cts; i++) begin : g_ctlist
      if (i < NUM_CTS) begin : g_used
         assign ctlist_rev[i] = CTLIST[NUM_CTS-1-i];
      end else begin : g_unused
         assign ctlist_rev[i] = 16'h0;              // past the end, controller errs
      end
   end

   assign list_id = ctlist_rev[entry];

   // feature bits
   always_comb begin
      feat_word = '0;
      feat_word[na_pkg::na_feat_mpsimple_bit] = ENABLE_MPSIMPLE;
      feat_word[na_pkg::na_feat_dma_bit]      = ENABLE_DMA;
   end

   // read mux
   always_comb begin
      case (sel)
         na_pkg::reg_tile_id:        read_word = TILE_ID;
         na_pkg::reg_num_tiles:      read_word = NUM_TILES;
         na_pkg::reg_features:       read_word = feat_word;
         na_pkg::reg_core_base:      read_word = CORE_BASE;
         na_pkg::reg_cores_per_tile: read_word = CORES_PER_TILE;
         na_pkg::reg_gmem_size:      read_word = GMEM_SIZE;
         na_pkg::reg_gmem_tile:      read_word = GMEM_TILE;
         na_pkg::reg_lmem_size:      read_word = LMEM_SIZE;
         na_pkg::reg_num_cts:        read_word = 32'(NUM_CTS);
         na_pkg::reg_seed:           read_word = seed;              // live lfsr state
         na_pkg::reg_dma_slots:      read_word = DMA_SLOTS;
         na_pkg::reg_cdc:            read_word = 32'd1;             // clock domains built in
         na_pkg::reg_cdc_dyn:        read_word = 32'd1;             // and switchable
         na_pkg::reg_cdc_conf:       read_word = {29'h0, cdc_conf};
         na_pkg::reg_ctlist: begin
            if (entry[0]) begin
               read_word = {16'h0, list_id};        // odd entry, lower half
            end else begin
               read_word = {list_id, 16'h0};        // even entry, upper half
            end
         end
         default:                    read_word = '0;                // reg_none
      endcase
   end

   // clock-domain setting and its enable pulse
   // pulse lines up with the ack cycle of the write
   always_ff @(posedge clk) begin
      if (rst) begin
         cdc_conf   <= CDC_DEFAULT;
         cdc_enable <= 1'b0;
      end else begin
         cdc_enable <= 1'b0;
         if (wr_en && (sel == na_pkg::reg_cdc_conf)) begin
            cdc_conf   <= wr_bits;
            cdc_enable <= 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

// File: verilog/na_conf_top.sv
// network adapter configuration block top, joins bus controller, register file and seed lfsr
`timescale 1ns/100ps
`default_nettype none

module na_conf_top #(
   parameter logic [31:0]        TILE_ID         = 32'd0,
   parameter logic [31:0]        CORE_BASE       = 32'd0,
   parameter logic [31:0]        NUM_TILES       = 32'd1,
   parameter logic [31:0]        CORES_PER_TILE  = 32'd1,
   parameter logic [31:0]        GMEM_SIZE       = 32'd0,
   parameter logic [31:0]        GMEM_TILE       = 32'd0,
   parameter logic [31:0]        LMEM_SIZE       = 32'd0,
   parameter logic [31:0]        DMA_SLOTS       = 32'd0,
   parameter logic               ENABLE_MPSIMPLE = 1'b0,
   parameter logic               ENABLE_DMA      = 1'b0,
   parameter int                 NUM_CTS         = 1,
   parameter na_pkg::na_ctlist_t CTLIST          = '0,
   parameter logic [2:0]         CDC_DEFAULT     = 3'd0,
   parameter logic [31:0]        SEED_INIT       = 32'h0000_0001
) (
   input  wire                           clk,
   input  wire                           rst,
   input  wire                           cyc,
   input  wire                           stb,
   input  wire [na_pkg::na_adr_w-1:0]    adr,
   input  wire                           we,
   input  wire [na_pkg::na_data_w-1:0]   wr_data,
   output logic [na_pkg::na_data_w-1:0]  rd_data,
   output logic                          ack,
   output logic                          err,
   output logic [2:0]                    cdc_conf,     // to clock-domain logic
   output logic                          cdc_enable
);

   na_pkg::na_reg_e               sel;
   logic [5:0]                    entry;
   logic                          wr_en;
   logic [2:0]                    wr_bits;
   logic                          seed_step;
   logic [na_pkg::na_data_w-1:0]  seed;
   logic [na_pkg::na_data_w-1:0]  read_word;

   na_bus_ctrl #(
      .NUM_CTS (NUM_CTS)
   ) u_bus_ctrl (
      .clk       (clk),
      .rst       (rst),
      .cyc       (cyc),
      .stb       (stb),
      .adr       (adr),
      .we        (we),
      .wr_data   (wr_data),
      .read_word (read_word),
      .rd_data   (rd_data),
      .ack       (ack),
      .err       (err),
      .sel       (sel),
      .entry     (entry),
      .wr_en     (wr_en),
      .wr_bits   (wr_bits),
      .seed_step (seed_step)
   );

   na_conf_regs #(
      .TILE_ID         (TILE_ID),
      .CORE_BASE       (CORE_BASE),
      .NUM_TILES       (NUM_TILES),
      .CORES_PER_TILE  (CORES_PER_TILE),
      .GMEM_SIZE       (GMEM_SIZE),
      .GMEM_TILE       (GMEM_TILE),
      .LMEM_SIZE       (LMEM_SIZE),
      .DMA_SLOTS       (DMA_SLOTS),
      .ENABLE_MPSIMPLE (ENABLE_MPSIMPLE),
      .ENABLE_DMA      (ENABLE_DMA),
      .NUM_CTS         (NUM_CTS),
      .CTLIST          (CTLIST),
      .CDC_DEFAULT     (CDC_DEFAULT)
   ) u_conf_regs (
      .clk        (clk),
      .rst        (rst),
      .sel        (sel),
      .entry      (entry),
      .wr_en      (wr_en),
      .wr_bits    (wr_bits),
      .seed       (seed),
      .read_word  (read_word),
      .cdc_conf   (cdc_conf),
      .cdc_enable (cdc_enable)
   );

   na_seed_gen #(
      .SEED_INIT (SEED_INIT)
   ) u_seed_gen (
      .clk       (clk),
      .rst       (rst),
      .seed_step (seed_step),
      .seed      (seed)
   );

endmodule

`default_nettype wire

// File: verilog/na_pkg.sv
// network adapter configuration package with widths, register selects and seed taps
`default_nettype none

package na_pkg;

   // bus widths
   localparam int na_data_w = 32;           // one register word
   localparam int na_adr_w  = 16;           // byte address seen by the adapter

   // compute tile list
   localparam int na_max_cts = 64;          // entries addressable in the list window

   // element i holds the tile id of compute tile i
   typedef logic [na_max_cts-1:0][15:0] na_ctlist_t;

   // register select handed from the bus controller to the register file
   typedef enum logic [3:0] {
      reg_tile_id,                          // 0x000
      reg_num_tiles,                        // 0x004
      reg_features,                         // 0x00c
      reg_core_base,                        // 0x010
      reg_cores_per_tile,                   // 0x018
      reg_gmem_size,                        // 0x01c
      reg_gmem_tile,                        // 0x020
      reg_lmem_size,                        // 0x024
      reg_num_cts,                          // 0x028
      reg_seed,                             // 0x02c
      reg_dma_slots,                        // 0x030
      reg_cdc,                              // 0x100
      reg_cdc_dyn,                          // 0x104
      reg_cdc_conf,                         // 0x108, only writable one
      reg_ctlist,                           // 0x200 .. 0x27e, halfword entries
      reg_none                              // no register behind the address
   } na_reg_e;

   // bus controller states
   typedef enum logic [1:0] {
      bus_idle,                             // waiting for cyc and stb
      bus_access,                           // request held, read word settles
      bus_respond                           // ack or err on the bus
   } na_bus_state_e;

   // bit positions in the features register
   localparam int na_feat_mpsimple_bit = 0;
   localparam int na_feat_dma_bit      = 1;

   // galois feedback mask for the seed lfsr
   // x^32 + x^22 + x^2 + x + 1, maximal length
   localparam logic [na_data_w-1:0] na_seed_taps = 32'h8020_0003;

endpackage

`default_nettype wire

// File: verilog/na_seed_gen.sv
// seed generator, a 32-bit galois lfsr stepped once per seed register read
`timescale 1ns/100ps
`default_nettype none

module na_seed_gen #(
   parameter logic [31:0] SEED_INIT = 32'h0000_0001   // must be nonzero
) (
   input  wire                           clk,
   input  wire                           rst,
   input  wire                           seed_step,   // one pulse per seed read
   output logic [na_pkg::na_data_w-1:0]  seed
);

   logic [na_pkg::na_data_w-1:0] seed_next;

   // right shift, fold the feedback mask in when a one drops out
   always_comb begin
      seed_next = {1'b0, seed[na_pkg::na_data_w-1:1]};
      if (seed[0]) begin
         seed_next = seed_next ^ na_pkg::na_seed_taps;
      end
   end

   // state only moves on a step
   // read data was already captured from the old value
   always_ff @(posedge clk) begin
      if (rst) begin
         seed <= SEED_INIT;
      end else if (seed_step) begin
         seed <= seed_next;
      end
   end

endmodule

`default_nettype wire
